// File: Bender.yml
package:
  name: kbd_letter

sources:
  - files:
      - kbd_pkg.sv
      - key_event_if.sv
      - ps2_rx.sv
      - kbd_scan_decoder.sv
      - key_letter_map.sv
      - char_out_port.sv
      - kbd_letter_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_kbd_letter.sv

// File: char_out_port.sv
`timescale 1ns/1ns
`default_nettype none

module char_out_port import kbd_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    letter_valid,
    input  letter_t letter,
    input  logic    char_ack,
    output logic    char_req,
    output letter_t char_letter,
    output logic    overflow
);

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    // Handshake states
    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_WAIT_HI = 2'd1;
    localparam logic [1:0] S_WAIT_LO = 2'd2;

    letter_t             mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic [1:0]          state;
    logic                full;
    logic                push;
    logic                pop;

    assign full = (count == CNT_BITS'(FIFO_DEPTH));
    assign push = letter_valid && !full;
    assign pop  = (state == S_WAIT_HI) && char_ack;

    ////////////////////////////////////////
    // Queue storage and pointers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= letter;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // Full queue drops the letter, pop in the same cycle does not help
            overflow <= letter_valid && full;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////
    // Four-phase sender
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (count != '0 && !char_ack) begin
                        state <= S_WAIT_HI;
                    end
                end
                S_WAIT_HI: begin
                    if (char_ack) begin
                        state <= S_WAIT_LO;
                    end
                end
                S_WAIT_LO: begin
                    if (!char_ack) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign char_req    = (state == S_WAIT_HI);
    assign char_letter = mem[rd_ptr];

    a_letter_stable: assert property (@(posedge clk) disable iff (rst)
        char_req && $past(char_req) |-> $stable(char_letter));

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_BITS'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: kbd_letter_top.sv
`timescale 1ns/1ns
`default_nettype none

module kbd_letter_top import kbd_pkg::*; #(
    parameter int FIFO_DEPTH    = 4,
    parameter int FRAME_TIMEOUT = 2000
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    ps2_clk,
    input  logic    ps2_data,
    input  logic    char_ack,
    output logic    char_req,
    output letter_t char_letter,
    output logic    parity_err,
    output logic    overflow
);

    logic       byte_valid;
    logic [7:0] byte_data;
    logic       letter_valid;
    letter_t    letter;

    key_event_if ev_if ();

    ////////////////////////////////////////
    // Keyboard side
    ////////////////////////////////////////

    ps2_rx #(
        .FRAME_TIMEOUT(FRAME_TIMEOUT)
    ) u_ps2_rx (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .byte_valid(byte_valid),
        .byte_data (byte_data),
        .parity_err(parity_err)
    );

    kbd_scan_decoder u_scan_decoder (
        .clk       (clk),
        .rst       (rst),
        .byte_valid(byte_valid),
        .byte_data (byte_data),
        .ev        (ev_if.source)
    );

    ////////////////////////////////////////
    // Letter side
    ////////////////////////////////////////

    key_letter_map u_letter_map (
        .clk         (clk),
        .rst         (rst),
        .ev          (ev_if.sink),
        .letter_valid(letter_valid),
        .letter      (letter)
    );

    char_out_port #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_out_port (
        .clk         (clk),
        .rst         (rst),
        .letter_valid(letter_valid),
        .letter      (letter),
        .char_ack    (char_ack),
        .char_req    (char_req),
        .char_letter (char_letter),
        .overflow    (overflow)
    );

endmodule

`default_nettype wire

// File: kbd_pkg.sv
`default_nettype none

package kbd_pkg;

    ////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////

    // Key code is extended flag plus scan byte
    localparam int CODE_BITS   = 9;
    localparam int KEY_COUNT   = 512;
    localparam int LETTER_BITS = 5;

    ////////////////////////////////////////
    // Set-2 prefix bytes
    ////////////////////////////////////////

    localparam logic [7:0] SCAN_BREAK = 8'hF0;
    localparam logic [7:0] SCAN_EXT   = 8'hE0;

    // Split view of a key code
    typedef struct packed {
        logic       ext;
        logic [7:0] scan;
    } kbd_code_s;

    // Raw view indexes the key map, split view feeds the mapper
    typedef union packed {
        logic [CODE_BITS-1:0] raw;
        kbd_code_s            fields;
    } kbd_code_u;

    // Letter number, 1 is A and 26 is Z, 0 means none
    typedef logic [LETTER_BITS-1:0] letter_t;

endpackage

`default_nettype wire

// File: kbd_scan_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module kbd_scan_decoder import kbd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    key_event_if.source ev
);

    logic                 break_flag;
    logic                 ext_flag;
    logic                 is_prefix;
    logic [KEY_COUNT-1:0] key_map;
    kbd_code_u            next_code;

    // Code of the byte on the input right now
    always_comb begin
        next_code.fields.ext  = ext_flag;
        next_code.fields.scan = byte_data;
    end

    assign is_prefix = (byte_data == SCAN_BREAK) || (byte_data == SCAN_EXT);

    ////////////////////////////////////////
    // Prefix flags and key map
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            break_flag <= 1'b0;
            ext_flag   <= 1'b0;
            key_map    <= '0;
            ev.valid   <= 1'b0;
        end else begin
            ev.valid <= 1'b0;
            if (byte_valid) begin
                if (byte_data == SCAN_BREAK) begin
                    break_flag <= 1'b1;
                end else if (byte_data == SCAN_EXT) begin
                    ext_flag <= 1'b1;
                end else begin
                    // Make sets the bit, break clears it
                    key_map[next_code.raw] <= ~break_flag;
                    ev.valid               <= 1'b1;
                    break_flag             <= 1'b0;
                    ext_flag               <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Event payload
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (byte_valid && !is_prefix) begin
            ev.code <= next_code;
            ev.make <= ~break_flag;
        end
    end

    // Map register already holds this event's update when valid is seen
    assign ev.key_down = key_map;

endmodule

`default_nettype wire

// File: key_event_if.sv
`timescale 1ns/1ns
`default_nettype none

interface key_event_if import kbd_pkg::*; ();

    // One-cycle pulse per key event
    logic                 valid;
    kbd_code_u            code;
    // Set for a press, clear for a release
    logic                 make;
    // Held keys, already updated for this event
    logic [KEY_COUNT-1:0] key_down;

    modport source (
        output valid,
        output code,
        output make,
        output key_down
    );

    modport sink (
        input valid,
        input code,
        input make,
        input key_down
    );

endinterface

`default_nettype wire

// File: key_letter_map.sv
`timescale 1ns/1ns
`default_nettype none

module key_letter_map import kbd_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    key_event_if.sink ev,
    output logic    letter_valid,
    output letter_t letter
);

    letter_t lut_letter;
    logic    hit;

    // Set-2 make codes of A to Z
    function automatic letter_t scan_to_letter(input logic [7:0] scan);
        case (scan)
            8'h1C: return 5'd1;
            8'h32: return 5'd2;
            8'h21: return 5'd3;
            8'h23: return 5'd4;
            8'h24: return 5'd5;
            8'h2B: return 5'd6;
            8'h34: return 5'd7;
            8'h33: return 5'd8;
            8'h43: return 5'd9;
            8'h3B: return 5'd10;
            8'h42: return 5'd11;
            8'h4B: return 5'd12;
            8'h3A: return 5'd13;
            8'h31: return 5'd14;
            8'h44: return 5'd15;
            8'h4D: return 5'd16;
            8'h15: return 5'd17;
            8'h2D: return 5'd18;
            8'h1B: return 5'd19;
            8'h2C: return 5'd20;
            8'h3C: return 5'd21;
            8'h2A: return 5'd22;
            8'h1D: return 5'd23;
            8'h22: return 5'd24;
            8'h35: return 5'd25;
            8'h1A: return 5'd26;
            default: return '0;
        endcase
    endfunction

    assign lut_letter = scan_to_letter(ev.code.fields.scan);

    // Extended keys never map, even when the byte matches a letter
    assign hit = ev.valid && ev.make && ev.key_down[ev.code.raw]
                 && !ev.code.fields.ext && (lut_letter != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            letter_valid <= 1'b0;
        end else begin
            letter_valid <= hit;
        end
    end

    always_ff @(posedge clk) begin
        letter <= lut_letter;
    end

    a_letter_nonzero: assert property (@(posedge clk) disable iff (rst)
        letter_valid |-> letter != '0);

endmodule

`default_nettype wire

// File: ps2_rx.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_rx #(
    parameter int FRAME_TIMEOUT = 2000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       parity_err
);

    localparam int TO_BITS = $clog2(FRAME_TIMEOUT + 1);

    logic [2:0]         clk_sync;
    logic [1:0]         data_sync;
    logic               clk_fall;
    logic               data_bit;
    logic [3:0]         bit_cnt;
    logic [7:0]         shreg;
    logic               parity_bit;
    logic [TO_BITS-1:0] idle_cnt;
    logic               frame_ok;

    ////////////////////////////////////////
    // Line synchronizers
    ////////////////////////////////////////

    // Both lines idle high
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign clk_fall = clk_sync[2] & ~clk_sync[1];
    assign data_bit = data_sync[1];

    ////////////////////////////////////////
    // Frame assembly
    ////////////////////////////////////////

    // Odd parity over data and parity bit, stop bit high
    assign frame_ok = (^{shreg, parity_bit}) & data_bit;

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            byte_valid <= 1'b0;
            parity_err <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            parity_err <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;
                    byte_valid <= frame_ok;
                    parity_err <= ~frame_ok;
                end else if (bit_cnt != 4'd0 || !data_bit) begin
                    // A high start bit is noise, wait for a real one
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                // Keyboard went quiet mid frame
                if (idle_cnt == TO_BITS'(FRAME_TIMEOUT - 1)) begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (clk_fall && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shreg <= {data_bit, shreg[7:1]};
        end
        if (clk_fall && bit_cnt == 4'd9) begin
            parity_bit <= data_bit;
        end
    end

    assign byte_data = shreg;

    a_no_dual_report: assert property (@(posedge clk) disable iff (rst)
        !(byte_valid && parity_err));

    a_bit_cnt_range: assert property (@(posedge clk) disable iff (rst)
        bit_cnt < 4'd11);

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
kbd_pkg.sv
key_event_if.sv
ps2_rx.sv
kbd_scan_decoder.sv
key_letter_map.sv
char_out_port.sv
kbd_letter_top.sv
tb_kbd_letter.sv

// File: tb_ps2_model.svh
`ifndef TB_PS2_MODEL_SVH
`define TB_PS2_MODEL_SVH

// Half of one PS/2 clock period in clk cycles
localparam int PS2_HALF = 8;

// Set-2 make codes in alphabet order, A is the top byte
localparam logic [26*8-1:0] LETTER_SCANS = {
    8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
    8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
    8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
};

// Scan code of letter idx+1
function automatic logic [7:0] letter_scan(input int idx);
    return LETTER_SCANS[(25 - idx) * 8 +: 8];
endfunction

// Reference table lookup, 0 when the byte is no letter key
function automatic letter_t model_letter(input logic [7:0] scan);
    for (int i = 0; i < 26; i++) begin
        if (letter_scan(i) == scan) begin
            return letter_t'(i + 1);
        end
    end
    return '0;
endfunction

////////////////////////////////////////
// PS/2 frame drivers
////////////////////////////////////////

// Start, 8 data bits LSB first, odd parity, stop
task automatic send_byte(input logic [7:0] value, input logic bad_parity);
    logic [10:0] frame;
    logic        par;
    par = ~^value;
    if (bad_parity) begin
        par = ~par;
    end
    frame = {1'b1, par, value, 1'b0};
    @(negedge clk);
    for (int i = 0; i < 11; i++) begin
        ps2_data = frame[i];
        repeat (PS2_HALF) @(negedge clk);
        ps2_clk = 1'b0;
        repeat (PS2_HALF) @(negedge clk);
        ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    // Idle gap, long enough for the result to reach the port
    repeat (PS2_HALF + 4) @(negedge clk);
endtask

task automatic send_make(input logic [7:0] scan, input logic ext);
    if (ext) begin
        send_byte(8'hE0, 1'b0);
    end
    send_byte(scan, 1'b0);
endtask

task automatic send_break(input logic [7:0] scan, input logic ext);
    if (ext) begin
        send_byte(8'hE0, 1'b0);
    end
    send_byte(8'hF0, 1'b0);
    send_byte(scan, 1'b0);
endtask

`endif

// File: tb_kbd_letter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_kbd_letter import kbd_pkg::*; ();

    // Same as the DUT default
    localparam int FIFO_DEPTH = 4;
    // Upper bound on frames sent over all tests
    localparam int FRAME_BUDGET = 1100;
    localparam int WATCHDOG_NS  = FRAME_BUDGET * 11 * 16 * 40 * 5 / 4 + 1000000;

    logic    clk = 1'b0;
    logic    rst;
    logic    ps2_clk;
    logic    ps2_data;
    logic    char_ack;
    logic    char_req;
    letter_t char_letter;
    logic    parity_err;
    logic    overflow;

    letter_t     exp_q[$];
    string       test_name;
    int          err_count;
    logic        ack_hold;
    int          parity_count;
    int          overflow_count;
    int          parity_mark;
    int          overflow_mark;
    logic [25:0] held;

    `include "tb_ps2_model.svh"

    kbd_letter_top dut (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .char_ack   (char_ack),
        .char_req   (char_req),
        .char_letter(char_letter),
        .parity_err (parity_err),
        .overflow   (overflow)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_letter(input string name, input letter_t exp, input letter_t got);
        if (got !== exp) begin
            err_count++;
            $display("Mismatch in %s: expected letter %0d, got %0d", name, exp, got);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            err_count++;
            $display("Mismatch in %s: expected %b, got %b", name, exp, got);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Pulses counted for the check after each key sequence
    always @(posedge clk) begin
        if (rst) begin
            parity_count   <= 0;
            overflow_count <= 0;
        end else begin
            if (parity_err) begin
                parity_count <= parity_count + 1;
            end
            if (overflow) begin
                overflow_count <= overflow_count + 1;
            end
        end
    end

    task automatic check_frame_flags(input logic exp_parity, input logic exp_overflow);
        int parity_new;
        int overflow_new;
        parity_new    = parity_count - parity_mark;
        overflow_new  = overflow_count - overflow_mark;
        parity_mark   = parity_count;
        overflow_mark = overflow_count;
        if (parity_new > 1 || overflow_new > 1) begin
            abort_run("More than one error pulse came from a single key sequence");
        end
        check_flag({test_name, " parity_err"}, exp_parity, parity_new != 0);
        check_flag({test_name, " overflow"}, exp_overflow, overflow_new != 0);
    endtask

    ////////////////////////////////////////
    // Model of key events
    ////////////////////////////////////////

    // A make of a plain letter key always yields a letter unless the queue drops it
    task automatic key_press(input logic [7:0] scan, input logic ext, input logic drop);
        letter_t l;
        l = ext ? letter_t'(0) : model_letter(scan);
        if (l != '0 && !drop) begin
            exp_q.push_back(l);
        end
        send_make(scan, ext);
        check_frame_flags(1'b0, (l != '0) && drop);
    endtask

    task automatic key_release(input logic [7:0] scan, input logic ext);
        send_break(scan, ext);
        check_frame_flags(1'b0, 1'b0);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || char_req || char_ack) begin
            @(negedge clk);
        end
    endtask

    // Consumer side of the four-phase handshake
    initial begin : consumer
        int      delay;
        letter_t want;
        char_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (char_req) begin
                delay = $urandom % 6;
                repeat (delay) @(negedge clk);
                while (ack_hold) begin
                    @(negedge clk);
                end
                if (exp_q.size() == 0) begin
                    abort_run("DUT offered a letter when none was expected");
                end
                want = exp_q.pop_front();
                check_letter(test_name, want, char_letter);
                char_ack = 1'b1;
                while (char_req) begin
                    @(negedge clk);
                end
                char_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish, the DUT or a handshake hung");
        $display("Verification failed");
        $fatal(1);
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        int unsigned seed;
        int unsigned rnd;
        int          idx;
        seed          = 32'hed3aa602;
        rnd           = $urandom(seed);
        err_count     = 0;
        ack_hold      = 1'b0;
        parity_mark   = 0;
        overflow_mark = 0;
        held          = '0;
        rst           = 1'b1;
        ps2_clk       = 1'b1;
        ps2_data      = 1'b1;
        test_name     = "reset";
        repeat (5) @(negedge clk);
        rst = 1'b0;

        test_name = "alphabet";
        for (int i = 0; i < 26; i++) begin
            key_press(letter_scan(i), 1'b0, 1'b0);
            key_release(letter_scan(i), 1'b0);
        end
        wait_drain();

        // Breaks, non-letter keys and extended keys stay silent
        test_name = "silent_keys";
        key_release(8'h1C, 1'b0);
        key_release(8'h1A, 1'b0);
        key_press(8'h29, 1'b0, 1'b0);
        key_release(8'h29, 1'b0);
        key_press(8'h16, 1'b0, 1'b0);
        key_release(8'h16, 1'b0);
        key_press(8'h5A, 1'b0, 1'b0);
        key_release(8'h5A, 1'b0);
        key_press(8'h1C, 1'b1, 1'b0);
        key_release(8'h1C, 1'b1);
        key_press(8'h75, 1'b1, 1'b0);
        key_release(8'h75, 1'b1);
        wait_drain();

        test_name = "bad_parity";
        send_byte(8'h1C, 1'b1);
        check_frame_flags(1'b1, 1'b0);
        key_press(8'h1C, 1'b0, 1'b0);
        key_release(8'h1C, 1'b0);
        wait_drain();

        // Consumer stalls so the queue fills up
        test_name = "overflow";
        ack_hold  = 1'b1;
        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            key_press(letter_scan(i), 1'b0, i >= FIFO_DEPTH);
            key_release(letter_scan(i), 1'b0);
        end
        ack_hold = 1'b0;
        wait_drain();

        test_name = "random_mix";
        for (int n = 0; n < 300; n++) begin
            rnd = $urandom % 10;
            idx = $urandom % 26;
            if (rnd < 5) begin
                key_press(letter_scan(idx), 1'b0, 1'b0);
                held[idx] = 1'b1;
            end else if (rnd < 7) begin
                key_release(letter_scan(idx), 1'b0);
                held[idx] = 1'b0;
            end else if (rnd == 7) begin
                case ($urandom % 3)
                    0: key_press(8'h29, 1'b0, 1'b0);
                    1: key_release(8'h29, 1'b0);
                    default: key_press(8'h66, 1'b0, 1'b0);
                endcase
            end else if (rnd == 8) begin
                if ($urandom % 2) begin
                    key_press(letter_scan(idx), 1'b1, 1'b0);
                end else begin
                    key_release(letter_scan(idx), 1'b1);
                end
            end else begin
                // Typematic repeat of the next held key from idx on
                for (int k = 0; k < 26; k++) begin
                    if (held[k] && k >= idx) begin
                        idx = k;
                        break;
                    end
                end
                key_press(letter_scan(idx), 1'b0, 1'b0);
                held[idx] = 1'b1;
            end
        end
        wait_drain();
        repeat (40) @(negedge clk);

        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
